/* bench/lsu_assert.sv */
// Bound LSU port checks; assumes req_i is the request in execute and responses come in order
`timescale 1ns/1ps
`default_nettype none

module lsu_assert
(
  input logic                 clk,
  input logic                 rst_n,
  input logic                 req_valid_i,
  input logic                 req_ready_o,
  input lsu_pkg::lsu_req_t    req_i,
  input logic                 misaligned_o,
  input logic                 bus_req_o,
  input logic                 bus_gnt_i,
  input lsu_pkg::bus_req_t    bus_o,
  input logic                 bus_rvalid_i,
  input logic                 result_valid_o
);

  logic [2:0] in_flight;                       // Granted and not yet answered
  logic       seen_req;                        // First request has come

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_flight <= '0;
      seen_req  <= 1'b0;
    end
    else
    begin
      in_flight <= in_flight + 3'(bus_req_o && bus_gnt_i) - 3'(bus_rvalid_i);
      if (req_valid_i)
        seen_req <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic is_misaligned(lsu_pkg::lsu_req_t req);
    logic [31:0] a;
    a = req.base + req.offset;
    return (req.size == lsu_pkg::SIZE_HALF && a[1:0] == 2'b11) ||
           (req.size == lsu_pkg::SIZE_WORD && a[1:0] != 2'b00);
  endfunction

  // Lanes ofs up to ofs+n-1 enabled; for stores each carries request byte (lane - ofs)
  function automatic logic steer_ok(lsu_pkg::lsu_req_t req, lsu_pkg::bus_req_t bus);
    logic [31:0] a;
    int          ofs;
    int          n;
    logic        ok;
    a   = req.base + req.offset;
    ofs = int'(a[1:0]);
    n   = (req.size == lsu_pkg::SIZE_BYTE) ? 1 : ((req.size == lsu_pkg::SIZE_HALF) ? 2 : 4);
    ok  = (bus.addr == a) && (bus.we == req.we);
    for (int i = 0; i < 4; i++)
    begin
      if (bus.be[i] != (i >= ofs && i < ofs + n))
        ok = 1'b0;
      else if (req.we && bus.be[i] && bus.wdata[8*i +: 8] != req.wdata[8*(i-ofs) +: 8])
        ok = 1'b0;                             // Store byte off its lane
    end
    return ok;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////////////////////

  a_steer: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o && bus_gnt_i |-> steer_ok(req_i, bus_o))
    else $error("Accepted transfer does not match address, direction, lanes or store data");

  a_limit: assert property (@(posedge clk) disable iff (!rst_n) in_flight <= 3'd2)
    else $error("More than two transfers outstanding");

  // Issue for every aligned request while a slot is free, a response freeing one at once
  a_issue: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o == (req_valid_i && !is_misaligned(req_i) && (in_flight < 3'd2 || bus_rvalid_i)))
    else $error("Bus request does not follow request validity and free slots");

  // Consumed on the fault strobe or on bus acceptance, never otherwise
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    req_ready_o == (req_valid_i && (is_misaligned(req_i) || (bus_req_o && bus_gnt_i))))
    else $error("Request ready does not match misalignment or bus acceptance");

  a_misaligned: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid_i && is_misaligned(req_i) |-> misaligned_o && req_ready_o && !bus_req_o)
    else $error("Misaligned request not rejected in its cycle");

  a_no_false_fault: assert property (@(posedge clk) disable iff (!rst_n)
    misaligned_o |-> req_valid_i && is_misaligned(req_i))
    else $error("Fault strobe without a misaligned request");

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_req && !req_valid_i |-> !bus_req_o && !result_valid_o && !misaligned_o)
    else $error("Output active after reset before any request");

endmodule

bind lsu_top lsu_assert i_lsu_assert
(
  .clk            ( clk            ),
  .rst_n          ( rst_n          ),
  .req_valid_i    ( req_valid_i    ),
  .req_ready_o    ( req_ready_o    ),
  .req_i          ( req_i          ),
  .misaligned_o   ( misaligned_o   ),
  .bus_req_o      ( bus_req_o      ),
  .bus_gnt_i      ( bus_gnt_i      ),
  .bus_o          ( bus_o          ),
  .bus_rvalid_i   ( bus_rvalid_i   ),
  .result_valid_o ( result_valid_o )
);

`default_nettype wire

/* bench/lsu_tb.sv */
// LSU testbench; in-order memory model with grant stalls and 1..4 cycle latency, addr[15:12]==E faults
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int NUM_REQ       = 400;          // Requests from execute
  localparam int REQ_TIMEOUT   = 64;           // Cycles to wait for consumption
  localparam int DRAIN_TIMEOUT = 64;           // Cycles to wait for last results

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid_i;
  logic                 req_ready_o;
  lsu_pkg::lsu_req_t    req_i;
  logic                 misaligned_o;
  logic                 bus_req_o;
  logic                 bus_gnt_i;
  lsu_pkg::bus_req_t    bus_o;
  logic                 bus_rvalid_i;
  lsu_pkg::bus_resp_t   bus_resp_i;
  logic                 result_valid_o;
  lsu_pkg::lsu_result_t result_o;

  logic [31:0]          rng;                   // Xorshift state
  int                   cycle;
  int                   n_results;
  int                   mismatches;
  int                   timeouts;
  lsu_pkg::lsu_result_t exp_q [$];             // Expected results in bus order
  lsu_pkg::bus_resp_t   resp_q [$];            // Pending memory responses
  int                   due_q [$];             // Earliest cycle for each response

  lsu_top i_lsu_top
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .req_valid_i    ( req_valid_i    ),
    .req_ready_o    ( req_ready_o    ),
    .req_i          ( req_i          ),
    .misaligned_o   ( misaligned_o   ),
    .bus_req_o      ( bus_req_o      ),
    .bus_gnt_i      ( bus_gnt_i      ),
    .bus_o          ( bus_o          ),
    .bus_rvalid_i   ( bus_rvalid_i   ),
    .bus_resp_i     ( bus_resp_i     ),
    .result_valid_o ( result_valid_o ),
    .result_o       ( result_o       )
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;                    // 100 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Models
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Sparse memory, every word reads as its own address scrambled
  function automatic logic [31:0] mem_word(logic [31:0] a);
    return {a[31:2], 2'b00} ^ 32'h5a3c_96e1;
  endfunction

  // Pick the addressed bytes and extend them, little endian
  function automatic logic [31:0] expect_load(logic [31:0] word, logic [1:0] ofs,
                                              lsu_pkg::lsu_size_e size, logic sgn);
    logic [7:0] b [0:3];
    logic [31:0] v;
    for (int i = 0; i < 4; i++)
      b[i] = word[8*i +: 8];
    case (size)
      lsu_pkg::SIZE_BYTE: v = (sgn && b[ofs][7]) ? {24'hff_ffff, b[ofs]} : {24'h0, b[ofs]};
      lsu_pkg::SIZE_HALF:
      begin
        if (sgn && b[ofs + 2'd1][7])
          v = {16'hffff, b[ofs + 2'd1], b[ofs]};
        else
          v = {16'h0000, b[ofs + 2'd1], b[ofs]};
      end
      default:            v = word;            // Word is only legal at offset 0
    endcase
    return v;
  endfunction

  task automatic make_request(output lsu_pkg::lsu_req_t req);
    logic [31:0] r;
    logic [1:0]  sz;
    r = next_rand();
    req.base = {16'h0000, r[15:0]};
    r = next_rand();
    req.offset = {{20{r[11]}}, r[11:0]};     // Signed immediate range
    sz = r[13:12];
    if (sz == 2'b11)
      sz = 2'b10;                            // Fold the unused code onto word
    req.size     = lsu_pkg::lsu_size_e'(sz);
    req.sign_ext = r[14];
    req.we       = r[15];
    req.wdata    = next_rand();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle driver, memory responder and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_result();
    lsu_pkg::lsu_result_t exp_res;
    string                name;
    logic                 ok;
    n_results++;
    if (exp_q.size() == 0)
    begin
      mismatches++;
      $display("Result strobe seen with no access outstanding");
      return;
    end
    exp_res = exp_q.pop_front();
    name = exp_res.err ? "bus_error" : (exp_res.we ? "store_resp" : "load_extend");
    if (exp_res.err)                           // Data is undefined on a fault
      ok = result_o.err && (result_o.we == exp_res.we) && (result_o.addr == exp_res.addr);
    else
      ok = (result_o == exp_res);
    if (!ok)
    begin
      mismatches++;
      $display("** Error %s: expected %h, actual %h", name, exp_res, result_o);
    end
  endtask

  // Transfer granted, queue its response and its expected result
  task automatic accept_transfer(input lsu_pkg::lsu_req_t req, input logic [31:0] r);
    logic [31:0]          a;
    lsu_pkg::lsu_result_t exp_res;
    lsu_pkg::bus_resp_t   resp;
    a = req.base + req.offset;
    resp.err   = (a[15:12] == 4'he);           // Faulting region
    resp.rdata = mem_word(a);
    exp_res.rdata = req.we ? 32'h0 : expect_load(resp.rdata, a[1:0], req.size, req.sign_ext);
    exp_res.err   = resp.err;
    exp_res.we    = req.we;
    exp_res.addr  = a;
    exp_q.push_back(exp_res);
    resp_q.push_back(resp);
    due_q.push_back(cycle + 1 + int'(r[4:3]));   // 1..4 cycles after grant
  endtask

  task automatic cycle_step(input logic valid, input lsu_pkg::lsu_req_t req,
                            output logic consumed);
    logic [31:0] r;
    @(negedge clk);
    r = next_rand();
    req_valid_i = valid;
    req_i       = req;
    bus_gnt_i   = (r[1:0] != 2'b00);           // Stall one cycle in four
    if (due_q.size() > 0 && due_q[0] <= cycle)
    begin
      bus_rvalid_i = 1'b1;
      bus_resp_i   = resp_q.pop_front();
      void'(due_q.pop_front());
    end
    else
    begin
      bus_rvalid_i = 1'b0;
      bus_resp_i   = '0;
    end
    #10;                                       // Outputs settled, well before posedge
    consumed = req_ready_o;
    if (result_valid_o)
      check_result();
    if (bus_req_o && bus_gnt_i)
      accept_transfer(req, r);
    cycle++;
  endtask

  task automatic send_request(input lsu_pkg::lsu_req_t req);
    logic done;
    int   waited;
    done   = 1'b0;
    waited = 0;
    while (!done && waited < REQ_TIMEOUT)
    begin
      cycle_step(1'b1, req, done);
      waited++;
    end
    if (!done)
    begin
      timeouts++;
      $display("Timeout: request to %h not consumed after %0d cycles",
               req.base + req.offset, REQ_TIMEOUT);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    lsu_pkg::lsu_req_t req;
    logic              done;
    int                waited;
    rng          = 32'hf8a0;
    cycle        = 0;
    n_results    = 0;
    mismatches   = 0;
    timeouts     = 0;
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_resp_i   = '0;
    req          = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) cycle_step(1'b0, req, done);   // Quiet window after reset
    for (int n = 0; n < NUM_REQ; n++)
    begin
      make_request(req);
      send_request(req);
      if (timeouts > 0)
        break;
      if (rng[7])
        cycle_step(1'b0, req, done);           // Occasional bubble
    end
    waited = 0;
    while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT)
    begin
      cycle_step(1'b0, req, done);
      waited++;
    end
    if (exp_q.size() > 0)
    begin
      timeouts++;
      $display("Timeout: %0d results still missing at end of run", exp_q.size());
    end
    $display("Results checked %0d, mismatches %0d, timeouts %0d",
             n_results, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/lsu_pkg.sv */
// Shared LSU types for a 32-bit little-endian bus; no misaligned split and at most two accesses in flight
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and limits
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN            = 32; // Data and address width
  localparam int unsigned BE_W            = 4;  // Byte lanes per word
  localparam int unsigned OFS_W           = 2;  // Byte offset within a word
  localparam int unsigned MAX_OUTSTANDING = 2;  // Accesses in flight on the bus
  localparam int unsigned CNT_W           = 2;  // Holds 0..MAX_OUTSTANDING

  // Access size, same encoding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////////////////////////////////////////
  // Core side
  ////////////////////////////////////////////////////////////////////////////

  // One load or store from execute
  typedef struct packed {
    logic [XLEN-1:0] base;      // rs1
    logic [XLEN-1:0] offset;    // Immediate, already sign extended
    lsu_size_e       size;
    logic            sign_ext;  // Load is signed (LB/LH)
    logic            we;        // Store
    logic [XLEN-1:0] wdata;     // rs2, unaligned
  } lsu_req_t;

  // Write-back result, also given for stores
  typedef struct packed {
    logic [XLEN-1:0] rdata;     // Zero for stores
    logic            err;       // Bus error on this access
    logic            we;
    logic [XLEN-1:0] addr;      // Faulting address when err is set
  } lsu_result_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [XLEN-1:0] addr;      // Byte address as computed
    logic            we;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;     // Already on its byte lanes
  } bus_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;     // Full word
    logic            err;
  } bus_resp_t;

  // Per access bookkeeping kept until its response
  typedef struct packed {
    lsu_size_e        size;
    logic             sign_ext;
    logic             we;
    logic [OFS_W-1:0] byte_ofs; // Lane of the lowest byte
    logic [XLEN-1:0]  addr;
  } txn_info_t;

endpackage

`default_nettype wire

/* hdl/lsu_rdata_align.sv */
// Response-side datapath; combinational, head_i must describe the access that bus_resp_i answers
`timescale 1ns/1ps
`default_nettype none

module lsu_rdata_align
(
  input  lsu_pkg::txn_info_t  head_i,        // Oldest outstanding access
  input  logic                bus_rvalid_i,
  input  lsu_pkg::bus_resp_t  bus_resp_i,
  output logic                result_valid_o,
  output lsu_pkg::lsu_result_t result_o
);

  logic [lsu_pkg::XLEN-1:0] rdata_sh;        // Addressed byte moved to lane 0
  logic [7:0]               byte_val;
  logic [15:0]              half_val;
  logic                     sign_b;          // Fill bit for bytes
  logic                     sign_h;          // Fill bit for halfwords
  logic [lsu_pkg::XLEN-1:0] rdata_ext;

  ////////////////////////////////////////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////////////////////////////////////////

  // Shift right by whole bytes, word accesses always have offset zero
  assign rdata_sh = bus_resp_i.rdata >> {head_i.byte_ofs, 3'b000};

  assign byte_val = rdata_sh[7:0];
  assign half_val = rdata_sh[15:0];      // Offset 3 never reaches here

  ////////////////////////////////////////////////////////////////////////////
  // Extension
  ////////////////////////////////////////////////////////////////////////////

  assign sign_b = head_i.sign_ext && byte_val[7];
  assign sign_h = head_i.sign_ext && half_val[15];

  always_comb
  begin
    case (head_i.size)
      lsu_pkg::SIZE_BYTE:
      begin
        rdata_ext = {{(lsu_pkg::XLEN-8){sign_b}}, byte_val};
      end
      lsu_pkg::SIZE_HALF:
      begin
        rdata_ext = {{(lsu_pkg::XLEN-16){sign_h}}, half_val};
      end
      default:
      begin
        rdata_ext = bus_resp_i.rdata;    // Word, passed as is
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  assign result_valid_o = bus_rvalid_i;  // Same cycle as the response

  always_comb
  begin
    result_o.rdata = head_i.we ? '0 : rdata_ext;  // Stores return zero
    result_o.err   = bus_resp_i.err;
    result_o.we    = head_i.we;
    result_o.addr  = head_i.addr;        // Address of the access, for mtval
  end

endmodule

`default_nettype wire

/* hdl/lsu_req_gen.sv */
// Request-side datapath; purely combinational, relies on req_i being held stable until consumed
`timescale 1ns/1ps
`default_nettype none

module lsu_req_gen
(
  input  lsu_pkg::lsu_req_t  req_i,      // Request in execute
  output lsu_pkg::bus_req_t  bus_o,      // Bus request payload
  output lsu_pkg::txn_info_t info_o,     // Bookkeeping for the response
  output logic               aligned_o   // Access may go to the bus
);

  logic [lsu_pkg::XLEN-1:0]   addr;      // Effective address
  logic [lsu_pkg::OFS_W-1:0]  ofs;       // Byte offset in word
  logic [lsu_pkg::BE_W-1:0]   be_mask;   // Lanes at offset zero
  logic [lsu_pkg::BE_W-1:0]   be;
  logic [2*lsu_pkg::XLEN-1:0] wdata_dbl; // Doubled word for the rotate
  logic [lsu_pkg::XLEN-1:0]   wdata_rot;

  ////////////////////////////////////////////////////////////////////////////
  // Address and alignment
  ////////////////////////////////////////////////////////////////////////////

  assign addr = req_i.base + req_i.offset;
  assign ofs  = addr[lsu_pkg::OFS_W-1:0];

  // Halfword may sit at offsets 0..2, word only at 0
  always_comb
  begin
    case (req_i.size)
      lsu_pkg::SIZE_BYTE: aligned_o = 1'b1;
      lsu_pkg::SIZE_HALF: aligned_o = (ofs != 2'b11);
      default:            aligned_o = (ofs == 2'b00); // Word, and the unused code
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////////////////////

  // Contiguous lanes for the size, before the offset is applied
  always_comb
  begin
    case (req_i.size)
      lsu_pkg::SIZE_BYTE: be_mask = 4'b0001;
      lsu_pkg::SIZE_HALF: be_mask = 4'b0011;
      default:            be_mask = 4'b1111;
    endcase
  end

  // Shift up to the first lane; lanes above bit 3 fall off,
  // which only happens for misaligned requests that never issue
  assign be = be_mask << ofs;

  ////////////////////////////////////////////////////////////////////////////
  // Store data steering
  ////////////////////////////////////////////////////////////////////////////

  // Rotate left by whole bytes so wdata[7:0] lands on lane ofs
  assign wdata_dbl = {req_i.wdata, req_i.wdata} << {ofs, 3'b000};
  assign wdata_rot = wdata_dbl[2*lsu_pkg::XLEN-1:lsu_pkg::XLEN]; // Upper half holds the rotation

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    bus_o.addr  = addr;          // Not word aligned, slave uses be
    bus_o.we    = req_i.we;
    bus_o.be    = be;
    bus_o.wdata = wdata_rot;
  end

  // What the aligner needs once the response comes back
  always_comb
  begin
    info_o.size     = req_i.size;
    info_o.sign_ext = req_i.sign_ext;
    info_o.we       = req_i.we;
    info_o.byte_ofs = ofs;
    info_o.addr     = addr;      // For error reporting
  end

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
// Load/store unit top; zero-cycle core to bus path, combinational result on rvalid, no back-pressure on results
`timescale 1ns/1ps
`default_nettype none

module lsu_top
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Execute request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  lsu_pkg::lsu_req_t    req_i,
  output logic                 misaligned_o,   // Fault strobe, request consumed

  // Bus request channel
  output logic                 bus_req_o,
  input  logic                 bus_gnt_i,
  output lsu_pkg::bus_req_t    bus_o,

  // Bus response channel
  input  logic                 bus_rvalid_i,
  input  lsu_pkg::bus_resp_t   bus_resp_i,

  // Write-back
  output logic                 result_valid_o,
  output lsu_pkg::lsu_result_t result_o
);

  lsu_pkg::txn_info_t info;     // Execute side bookkeeping
  lsu_pkg::txn_info_t head;     // Oldest access in flight
  logic               aligned;

  ////////////////////////////////////////////////////////////////////////////
  // Execute side
  ////////////////////////////////////////////////////////////////////////////

  lsu_req_gen i_lsu_req_gen
  (
    .req_i     ( req_i   ),
    .bus_o     ( bus_o   ),
    .info_o    ( info    ),
    .aligned_o ( aligned )
  );

  // Issue control and the buffer of accesses in flight
  lsu_txn_queue i_lsu_txn_queue
  (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .req_valid_i  ( req_valid_i  ),
    .aligned_i    ( aligned      ),
    .info_i       ( info         ),
    .bus_req_o    ( bus_req_o    ),
    .bus_gnt_i    ( bus_gnt_i    ),
    .bus_rvalid_i ( bus_rvalid_i ),
    .req_ready_o  ( req_ready_o  ),
    .misaligned_o ( misaligned_o ),
    .head_o       ( head         )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  lsu_rdata_align i_lsu_rdata_align
  (
    .head_i         ( head           ),
    .bus_rvalid_i   ( bus_rvalid_i   ),
    .bus_resp_i     ( bus_resp_i     ),
    .result_valid_o ( result_valid_o ),
    .result_o       ( result_o       )
  );

endmodule

`default_nettype wire

/* hdl/lsu_txn_queue.sv */
// Issue control and response bookkeeping; responses must come in order, one per grant, never in the grant cycle
`timescale 1ns/1ps
`default_nettype none

module lsu_txn_queue
(
  input  logic               clk,
  input  logic               rst_n,

  // Execute handshake
  input  logic               req_valid_i,
  input  logic               aligned_i,    // From request generator
  input  lsu_pkg::txn_info_t info_i,       // Pushed on grant

  // Bus handshake
  output logic               bus_req_o,
  input  logic               bus_gnt_i,
  input  logic               bus_rvalid_i,

  output logic               req_ready_o,
  output logic               misaligned_o, // Single cycle fault strobe
  output lsu_pkg::txn_info_t head_o        // Oldest outstanding access
);

  logic [lsu_pkg::CNT_W-1:0] cnt_q;        // Accesses in flight
  logic [lsu_pkg::CNT_W-1:0] cnt_d;
  logic                      slot_free;
  logic                      push;         // Accepted on the bus
  logic                      pop;          // Response this cycle

  logic [$clog2(lsu_pkg::MAX_OUTSTANDING)-1:0] wr_ptr_q;
  logic [$clog2(lsu_pkg::MAX_OUTSTANDING)-1:0] rd_ptr_q;

  lsu_pkg::txn_info_t info_mem [0:lsu_pkg::MAX_OUTSTANDING-1];

  ////////////////////////////////////////////////////////////////////////////
  // Issue gating
  ////////////////////////////////////////////////////////////////////////////

  // A response in this cycle frees its slot right away
  assign slot_free = (cnt_q < lsu_pkg::CNT_W'(lsu_pkg::MAX_OUTSTANDING)) || bus_rvalid_i;

  assign bus_req_o    = req_valid_i && aligned_i && slot_free;
  assign push         = bus_req_o && bus_gnt_i;
  assign pop          = bus_rvalid_i;
  assign misaligned_o = req_valid_i && !aligned_i;   // Dropped without bus access

  // Aligned requests leave execute in the grant cycle
  assign req_ready_o  = push || misaligned_o;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case ({push, pop})
      2'b10:   cnt_d = cnt_q + lsu_pkg::CNT_W'(1);
      2'b01:   cnt_d = cnt_q - lsu_pkg::CNT_W'(1);
      default: cnt_d = cnt_q;                        // Idle, or both cancel
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_d;
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;                 // Wraps at depth
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Info buffer
  ////////////////////////////////////////////////////////////////////////////

  // Payload only; the pointers say which entries are live.
  // When full, push and pop hit the same entry, and head_o still
  // shows the old one for the response in that cycle
  always_ff @(posedge clk)
  begin
    if (push)
      info_mem[wr_ptr_q] <= info_i;
  end

  assign head_o = info_mem[rd_ptr_q];

endmodule

`default_nettype wire

/* list.f */
hdl/lsu_pkg.sv
hdl/lsu_req_gen.sv
hdl/lsu_txn_queue.sv
hdl/lsu_rdata_align.sv
hdl/lsu_top.sv
bench/lsu_assert.sv
bench/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lsu_tb -f list.f -o lsu_sim

# The simulator stops with a nonzero status on an assertion, so keep its output
out=$(./obj_dir/lsu_sim 2>&1) || true
echo "$out"

echo "$out" | grep -q "NO ERRORS"
